//--- hdl/ntt_defines.svh
/*
 * Shared widths, depths, register slots and modulus constants for the
 * pointwise-multiply coefficient store
 */
`ifndef NTT_DEFINES_SVH
`define NTT_DEFINES_SVH

// Coefficient storage and arithmetic widths
`define NTT_COEF_W      24
`define NTT_MUL_W       23
`define NTT_PROD_W      46
`define NTT_Q           23'd8380417
// floor(2^48 / q) for a 48-bit Barrett shift
`define NTT_BARRETT_M   26'd33587228

// Memory geometry, four slots per row
`define NTT_SLOTS       256
`define NTT_ROWS        64
`define NTT_ADDR_W      9
`define NTT_ROW_W       6
`define NTT_ROW_DATA_W  96

// Host bus
`define NTT_AXI_ADDR_W  12
`define NTT_AXI_DATA_W  32
`define NTT_RESP_OKAY   2'b00
`define NTT_RESP_SLVERR 2'b10

// Register slots above the coefficient area
`define NTT_REG_CTRL    9'd256
`define NTT_REG_SCALAR  9'd257
`define NTT_REG_STATUS  9'd258

`endif

//--- hdl/ntt_pkg.sv
/*
 * Packed request, row and status structs exchanged between the bus
 * decoder, the coefficient memory and the multiply pipeline
 */
`include "ntt_defines.svh"

package ntt_pkg;

    // One single-slot host access, issued in the bus handshake cycle
    typedef struct packed {
        logic                     valid;
        logic                     write;
        logic [`NTT_ADDR_W-1:0]   addr;
        logic [`NTT_COEF_W-1:0]   data;
    } host_req_t;

    // Engine row read request, data returns one cycle later
    typedef struct packed {
        logic                     valid;
        logic [`NTT_ROW_W-1:0]    row;
    } row_rd_t;

    // Engine row write, slot 0 of the row sits in the low 24 bits
    typedef struct packed {
        logic                        valid;
        logic [`NTT_ROW_W-1:0]       row;
        logic [`NTT_ROW_DATA_W-1:0]  data;
    } row_wr_t;

    // Four unreduced products of one row
    typedef struct packed {
        logic                             valid;
        logic [`NTT_ROW_W-1:0]            row;
        logic [3:0][`NTT_PROD_W-1:0]      p;
    } prod_row_t;

    // Engine state as seen by the status register
    typedef struct packed {
        logic busy;
        logic done;
    } engine_stat_t;

endpackage

//--- hdl/ntt_axil_decode.sv
/*
 * AXI4-Lite slave front end. Turns bus writes and reads into single-slot
 * memory accesses and answers with OKAY or SLVERR
 */
`timescale 1ns/1ps
`include "ntt_defines.svh"

module ntt_axil_decode import ntt_pkg::*; (
    input  logic                        clk,
    input  logic                        reset_n,
    input  logic [`NTT_AXI_ADDR_W-1:0]  awaddr,
    input  logic                        awvalid,
    output logic                        awready,
    input  logic [`NTT_AXI_DATA_W-1:0]  wdata,
    input  logic [3:0]                  wstrb,
    input  logic                        wvalid,
    output logic                        wready,
    output logic [1:0]                  bresp,
    output logic                        bvalid,
    input  logic                        bready,
    input  logic [`NTT_AXI_ADDR_W-1:0]  araddr,
    input  logic                        arvalid,
    output logic                        arready,
    output logic [`NTT_AXI_DATA_W-1:0]  rdata,
    output logic [1:0]                  rresp,
    output logic                        rvalid,
    input  logic                        rready,
    input  logic                        busy,
    output host_req_t                   host_req,
    input  logic [`NTT_COEF_W-1:0]      host_rdata
);

    logic [`NTT_ADDR_W-1:0] aw_slot;
    logic [`NTT_ADDR_W-1:0] ar_slot;
    logic                   ar_ok;
    logic                   wr_ok;
    logic                   wr_go;
    logic                   rd_go;
    logic                   rd_err;

    // Word aligned and no higher than the status slot
    function automatic logic in_range(input logic [`NTT_AXI_ADDR_W-1:0] addr);
        return (addr[1:0] == 2'b00) && !addr[`NTT_AXI_ADDR_W-1] &&
               (addr[`NTT_ADDR_W+1:2] <= `NTT_REG_STATUS);
    endfunction

    assign aw_slot = awaddr[`NTT_ADDR_W+1:2];
    assign ar_slot = araddr[`NTT_ADDR_W+1:2];
    assign ar_ok   = in_range(araddr);

    // Only full writes of the coefficient bytes are taken.
    // Coefficient slots are locked while the engine owns the memory
    assign wr_ok = in_range(awaddr) && (wstrb[2:0] == 3'b111) &&
                   !(busy && (aw_slot < `NTT_REG_CTRL));

    // The ready strobes are registered single-cycle pulses and writes win
    // over reads, so at most one host access reaches the memory per cycle
    assign wr_go = awvalid && wvalid && !awready && !bvalid && !arready;
    assign rd_go = arvalid && !arready && !rvalid && !wr_go && !awready;

    // ======================================================================
    // Handshake and response state
    // ======================================================================
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            awready <= 1'b0;
            wready  <= 1'b0;
            arready <= 1'b0;
            bvalid  <= 1'b0;
            bresp   <= `NTT_RESP_OKAY;
            rvalid  <= 1'b0;
            rresp   <= `NTT_RESP_OKAY;
            rd_err  <= 1'b0;
        end else begin
            awready <= wr_go;
            wready  <= wr_go;
            arready <= rd_go;

            // Response is held until the master takes it
            if (awready) begin
                bvalid <= 1'b1;
                bresp  <= wr_ok ? `NTT_RESP_OKAY : `NTT_RESP_SLVERR;
            end else if (bready) begin
                bvalid <= 1'b0;
            end

            // Read data lands from memory in the cycle rvalid rises
            if (arready) begin
                rvalid <= 1'b1;
                rresp  <= ar_ok ? `NTT_RESP_OKAY : `NTT_RESP_SLVERR;
                rd_err <= !ar_ok;
            end else if (rready) begin
                rvalid <= 1'b0;
            end
        end
    end

    // The memory holds host_rdata until the next read, so it is stable
    // for as long as rvalid waits on rready
    assign rdata = rd_err ? '0 : `NTT_AXI_DATA_W'(host_rdata);

    // Memory access is issued in the transfer cycle of AW and W or AR
    always_comb begin
        host_req = '0;
        if (awready) begin
            host_req.valid = wr_ok;
            host_req.write = 1'b1;
            host_req.addr  = aw_slot;
            host_req.data  = wdata[`NTT_COEF_W-1:0];
        end else if (arready) begin
            host_req.valid = ar_ok;
            host_req.addr  = ar_slot;
        end
    end

endmodule

//--- hdl/ntt_special_mem.sv
/*
 * Coefficient store with a single-slot host port and a four-slot row
 * port for the engine, plus the ctrl, scalar and status registers
 */
`timescale 1ns/1ps
`include "ntt_defines.svh"

module ntt_special_mem import ntt_pkg::*; (
    input  logic                        clk,
    input  logic                        reset_n,
    input  host_req_t                   host_req,
    output logic [`NTT_COEF_W-1:0]      host_rdata,
    input  row_rd_t                     row_rd,
    output logic [`NTT_ROW_DATA_W-1:0]  row_rdata,
    input  row_wr_t                     row_wr,
    input  engine_stat_t                stat,
    output logic                        start,
    output logic [`NTT_MUL_W-1:0]       scalar
);

    logic [`NTT_COEF_W-1:0] coef [`NTT_SLOTS];
    logic                   host_wr;
    logic                   ctrl_wr;
    logic                   zeroize;
    logic                   start_q;
    logic [`NTT_MUL_W-1:0]  scalar_q;
    logic                   done_q;
    logic                   busy_q;

    assign host_wr = host_req.valid && host_req.write;
    assign ctrl_wr = host_wr && (host_req.addr == `NTT_REG_CTRL);
    assign zeroize = ctrl_wr && host_req.data[1];

    // ======================================================================
    // Coefficient array
    // ======================================================================
    always_ff @(posedge clk) begin
        if (zeroize) begin
            for (int i = 0; i < `NTT_SLOTS; i++) begin
                coef[i] <= '0;
            end
        end else begin
            if (host_wr && (host_req.addr < `NTT_REG_CTRL)) begin
                coef[host_req.addr[7:0]] <= host_req.data;
            end
            // A row write splits into its four slots in one cycle
            if (row_wr.valid) begin
                for (int k = 0; k < 4; k++) begin
                    coef[{row_wr.row, 2'(k)}] <= row_wr.data[k*`NTT_COEF_W +: `NTT_COEF_W];
                end
            end
        end
    end

    // Host read port, the value stays until the next read
    always_ff @(posedge clk) begin
        if (host_req.valid && !host_req.write) begin
            case (host_req.addr)
                `NTT_REG_CTRL:   host_rdata <= `NTT_COEF_W'(start_q);
                `NTT_REG_SCALAR: host_rdata <= `NTT_COEF_W'(scalar_q);
                `NTT_REG_STATUS: host_rdata <= `NTT_COEF_W'({stat.busy, done_q});
                default:         host_rdata <= host_req.addr[8] ? '0 : coef[host_req.addr[7:0]];
            endcase
        end
    end

    // Row read concatenates four slots, slot 0 in the low bits
    always_ff @(posedge clk) begin
        if (row_rd.valid) begin
            for (int k = 0; k < 4; k++) begin
                row_rdata[k*`NTT_COEF_W +: `NTT_COEF_W] <= coef[{row_rd.row, 2'(k)}];
            end
        end
    end

    // ======================================================================
    // Control and status registers
    // ======================================================================
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            start_q  <= 1'b0;
            scalar_q <= '0;
            done_q   <= 1'b0;
            busy_q   <= 1'b0;
        end else begin
            busy_q <= stat.busy;
            // Start is a one-cycle pulse and is dropped while the engine runs
            start_q <= ctrl_wr && host_req.data[0] && !host_req.data[1] && !stat.busy;
            if (zeroize) begin
                scalar_q <= '0;
                done_q   <= 1'b0;
            end else begin
                if (host_wr && (host_req.addr == `NTT_REG_SCALAR)) begin
                    scalar_q <= host_req.data[`NTT_MUL_W-1:0];
                end
                // Done drops with the start pulse, so status never shows it with busy.
                // It is taken once at the end of a pass, so zeroize can clear it
                if (stat.busy || start_q) begin
                    done_q <= 1'b0;
                end else if (stat.done && busy_q) begin
                    done_q <= 1'b1;
                end
            end
        end
    end

    assign start  = start_q;
    assign scalar = scalar_q;

endmodule

//--- hdl/ntt_pwm_execute.sv
/*
 * Row sequencer and multiply stage. Issues the 64 row reads of a pass
 * and registers each coefficient times the scalar
 */
`timescale 1ns/1ps
`include "ntt_defines.svh"

module ntt_pwm_execute import ntt_pkg::*; (
    input  logic                        clk,
    input  logic                        reset_n,
    input  logic                        start,
    input  logic [`NTT_MUL_W-1:0]       scalar,
    output row_rd_t                     row_rd,
    input  logic [`NTT_ROW_DATA_W-1:0]  row_rdata,
    output prod_row_t                   prod
);

    logic                            run;
    logic [`NTT_ROW_W-1:0]           row_cnt;
    logic [`NTT_MUL_W-1:0]           scalar_q;
    logic                            rd_valid_q;
    logic [`NTT_ROW_W-1:0]           rd_row_q;
    logic                            prod_valid_q;
    logic [`NTT_ROW_W-1:0]           prod_row_q;
    logic [3:0][`NTT_PROD_W-1:0]     prod_q;

    // One read per cycle for rows 0 to 63, no stalls
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            run          <= 1'b0;
            row_cnt      <= '0;
            rd_valid_q   <= 1'b0;
            prod_valid_q <= 1'b0;
        end else begin
            if (start && !run) begin
                run     <= 1'b1;
                row_cnt <= '0;
            end else if (run) begin
                row_cnt <= row_cnt + 1'b1;
                if (row_cnt == `NTT_ROWS - 1) begin
                    run <= 1'b0;
                end
            end
            // Valid follows the memory latency and then the multiply register
            rd_valid_q   <= run;
            prod_valid_q <= rd_valid_q;
        end
    end

    // Scalar is frozen for the whole pass
    always_ff @(posedge clk) begin
        if (start && !run) begin
            scalar_q <= scalar;
        end
        rd_row_q   <= row_cnt;
        prod_row_q <= rd_row_q;
        for (int k = 0; k < 4; k++) begin
            prod_q[k] <= row_rdata[k*`NTT_COEF_W +: `NTT_MUL_W] * scalar_q;
        end
    end

    assign row_rd.valid = run;
    assign row_rd.row   = row_cnt;

    assign prod.valid = prod_valid_q;
    assign prod.row   = prod_row_q;
    assign prod.p     = prod_q;

endmodule

//--- hdl/ntt_pwm_result.sv
/*
 * Barrett reduction of each row of products, packed write-back to the
 * memory, and the busy and done flags of a pass
 */
`timescale 1ns/1ps
`include "ntt_defines.svh"

module ntt_pwm_result import ntt_pkg::*; (
    input  logic          clk,
    input  logic          reset_n,
    input  logic          start,
    input  prod_row_t     prod,
    output row_wr_t       row_wr,
    output engine_stat_t  stat
);

    logic                          wr_valid_q;
    logic [`NTT_ROW_W-1:0]         wr_row_q;
    logic [3:0][`NTT_COEF_W-1:0]   wr_data_q;
    logic [3:0][`NTT_COEF_W-1:0]   red;
    logic                          busy_q;
    logic                          done_q;

    // The estimate is at most one short, so r lies below 2q and fits 25 bits
    function automatic logic [`NTT_MUL_W-1:0] barrett(input logic [`NTT_PROD_W-1:0] p);
        logic [71:0] est;
        logic [23:0] qhat;
        logic [47:0] diff;
        logic [24:0] r;
        est  = 72'(p) * 72'(`NTT_BARRETT_M);
        qhat = est[71:48];
        diff = 48'(p) - 48'(qhat) * 48'(`NTT_Q);
        r    = diff[24:0];
        if (r >= 25'(`NTT_Q)) begin
            r = r - 25'(`NTT_Q);
        end
        return r[`NTT_MUL_W-1:0];
    endfunction

    always_comb begin
        for (int k = 0; k < 4; k++) begin
            red[k] = `NTT_COEF_W'(barrett(prod.p[k]));
        end
    end

    // ======================================================================
    // Write-back register and pass flags
    // ======================================================================
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            wr_valid_q <= 1'b0;
            busy_q     <= 1'b0;
            done_q     <= 1'b0;
        end else begin
            wr_valid_q <= prod.valid;
            if (start && !busy_q) begin
                busy_q <= 1'b1;
                done_q <= 1'b0;
            end else if (wr_valid_q && (wr_row_q == `NTT_ROWS - 1)) begin
                // Last row is in the memory this cycle
                busy_q <= 1'b0;
                done_q <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        wr_row_q  <= prod.row;
        wr_data_q <= red;
    end

    assign row_wr.valid = wr_valid_q;
    assign row_wr.row   = wr_row_q;
    assign row_wr.data  = wr_data_q;

    assign stat.busy = busy_q;
    assign stat.done = done_q;

endmodule

//--- hdl/ntt_pwm_top.sv
/*
 * Pointwise-multiply subsystem top. AXI4-Lite decode, coefficient
 * memory, multiply stage and reduction stage
 */
`timescale 1ns/1ps
`include "ntt_defines.svh"

module ntt_pwm_top import ntt_pkg::*; (
    input  logic                        clk,
    input  logic                        reset_n,
    input  logic [`NTT_AXI_ADDR_W-1:0]  awaddr,
    input  logic                        awvalid,
    output logic                        awready,
    input  logic [`NTT_AXI_DATA_W-1:0]  wdata,
    input  logic [3:0]                  wstrb,
    input  logic                        wvalid,
    output logic                        wready,
    output logic [1:0]                  bresp,
    output logic                        bvalid,
    input  logic                        bready,
    input  logic [`NTT_AXI_ADDR_W-1:0]  araddr,
    input  logic                        arvalid,
    output logic                        arready,
    output logic [`NTT_AXI_DATA_W-1:0]  rdata,
    output logic [1:0]                  rresp,
    output logic                        rvalid,
    input  logic                        rready
);

    host_req_t                   host_req;
    logic [`NTT_COEF_W-1:0]      host_rdata;
    row_rd_t                     row_rd;
    logic [`NTT_ROW_DATA_W-1:0]  row_rdata;
    row_wr_t                     row_wr;
    prod_row_t                   prod;
    engine_stat_t                stat;
    logic                        start;
    logic [`NTT_MUL_W-1:0]       scalar;

    // Host side, locked out of the coefficients while busy
    ntt_axil_decode u_decode (
        .clk        (clk),
        .reset_n    (reset_n),
        .awaddr     (awaddr),
        .awvalid    (awvalid),
        .awready    (awready),
        .wdata      (wdata),
        .wstrb      (wstrb),
        .wvalid     (wvalid),
        .wready     (wready),
        .bresp      (bresp),
        .bvalid     (bvalid),
        .bready     (bready),
        .araddr     (araddr),
        .arvalid    (arvalid),
        .arready    (arready),
        .rdata      (rdata),
        .rresp      (rresp),
        .rvalid     (rvalid),
        .rready     (rready),
        .busy       (stat.busy),
        .host_req   (host_req),
        .host_rdata (host_rdata)
    );

    ntt_special_mem u_mem (
        .clk        (clk),
        .reset_n    (reset_n),
        .host_req   (host_req),
        .host_rdata (host_rdata),
        .row_rd     (row_rd),
        .row_rdata  (row_rdata),
        .row_wr     (row_wr),
        .stat       (stat),
        .start      (start),
        .scalar     (scalar)
    );

    // Engine: read, multiply, reduce, write back
    ntt_pwm_execute u_execute (
        .clk       (clk),
        .reset_n   (reset_n),
        .start     (start),
        .scalar    (scalar),
        .row_rd    (row_rd),
        .row_rdata (row_rdata),
        .prod      (prod)
    );

    ntt_pwm_result u_result (
        .clk     (clk),
        .reset_n (reset_n),
        .start   (start),
        .prod    (prod),
        .row_wr  (row_wr),
        .stat    (stat)
    );

endmodule

//--- bench/ntt_pwm_chk.sv
/*
 * Bound assertions on the AXI4-Lite valid/ready handshakes of the decoder
 * and on the write-back and pass flags of the reduction stage
 */
`timescale 1ns/1ps
`include "ntt_defines.svh"

module ntt_pwm_chk import ntt_pkg::*; (
    input logic          clk,
    input logic          reset_n,
    // Channel order is AW, W, AR, B, R
    input logic [4:0]    valid,
    input logic [4:0]    ready,
    input row_wr_t       row_wr,
    input engine_stat_t  stat
);

    // Read by the testbench at the end of the run
    int fail_count = 0;

    // A raised valid holds until the cycle where ready meets it
    for (genvar i = 0; i < 5; i++) begin : g_hold
        a_valid_hold: assert property (@(posedge clk) disable iff (!reset_n)
            (valid[i] && !ready[i]) |=> valid[i])
        else begin
            fail_count++;
            $error("AXI valid on channel %0d dropped before its transfer", i);
        end
    end

    // Rows come back in order, one per cycle, until the last row of the pass
    a_row_order: assert property (@(posedge clk) disable iff (!reset_n)
        (row_wr.valid && (row_wr.row != `NTT_ROWS - 1)) |=>
            (row_wr.valid && (row_wr.row == $past(row_wr.row) + 1'b1)))
    else begin
        fail_count++;
        $error("Row write-back out of order or interrupted");
    end

    // Once the pass reports done the engine is idle and writes nothing back
    a_busy_done: assert property (@(posedge clk) disable iff (!reset_n)
        stat.done |-> !(stat.busy || row_wr.valid))
    else begin
        fail_count++;
        $error("Engine active while showing done");
    end

endmodule

// Handshake checks sit on the bus decoder, engine checks on the result stage
bind ntt_axil_decode ntt_pwm_chk u_axi_chk (
    .clk     (clk),
    .reset_n (reset_n),
    .valid   ({rvalid, bvalid, arvalid, wvalid, awvalid}),
    .ready   ({rready, bready, arready, wready, awready}),
    .row_wr  ('0),
    .stat    ('0)
);

bind ntt_pwm_result ntt_pwm_chk u_eng_chk (
    .clk     (clk),
    .reset_n (reset_n),
    .valid   (5'b0),
    .ready   (5'b0),
    .row_wr  (row_wr),
    .stat    (stat)
);

//--- bench/ntt_pwm_tb.sv
/*
 * Testbench for the pointwise-multiply subsystem. Fills the store over
 * AXI4-Lite, runs a pass per table row and checks every slot against a
 * coefficient times scalar modulo q model
 */
`timescale 1ns/1ps
`include "ntt_defines.svh"

module ntt_pwm_tb;

    localparam time    DRIVE_DLY  = 1ns;
    localparam int     NUM_TESTS  = 5;
    localparam int     POLL_LIMIT = 200;
    localparam longint Q          = `NTT_Q;
    localparam int     POKE_SLOT  = 5;
    // One access takes about four cycles plus a stall of up to seven
    localparam int     ACCESS_CYCLES  = 16;
    localparam int     TIMEOUT_CYCLES = (NUM_TESTS + 2) * (2 * `NTT_SLOTS + 32) * ACCESS_CYCLES;

    localparam logic [11:0] CTRL_ADDR   = 12'({`NTT_REG_CTRL, 2'b00});
    localparam logic [11:0] SCALAR_ADDR = 12'({`NTT_REG_SCALAR, 2'b00});
    localparam logic [11:0] STATUS_ADDR = 12'({`NTT_REG_STATUS, 2'b00});

    // One table row, a pass with its scalar and the expected response codes
    typedef struct packed {
        logic [`NTT_MUL_W-1:0] scalar;
        logic                  stall;
        logic                  busy_poke;
        logic [1:0]            poke_resp;
    } test_row_t;

    logic        clk;
    logic        reset_n;
    logic [11:0] awaddr;
    logic        awvalid;
    logic        awready;
    logic [31:0] wdata;
    logic [3:0]  wstrb;
    logic        wvalid;
    logic        wready;
    logic [1:0]  bresp;
    logic        bvalid;
    logic        bready;
    logic [11:0] araddr;
    logic        arvalid;
    logic        arready;
    logic [31:0] rdata;
    logic [1:0]  rresp;
    logic        rvalid;
    logic        rready;

    test_row_t tests [NUM_TESTS];
    integer    seed;
    int        errors       = 0;
    int        tests_run    = 0;
    int        tests_failed = 0;
    int        cycle_count  = 0;

    ntt_pwm_top uut (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // Watchdog sized from the number of accesses of all tests
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Run stopped at %0t, no end after %0d cycles", $time, cycle_count);
            $display("TEST FAILED");
            $finish;
        end
    end

    // ========================================================================
    // Reporting and reference model
    // ========================================================================
    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        $display("Fail at %0t: %s expected %h got %h", $time, name, exp, got);
        errors++;
    endtask

    task automatic report_problem(input string msg);
        $display("Error at %0t: %s", $time, msg);
        errors++;
    endtask

    task automatic finish_test(input string name, input int errs_before);
        tests_run++;
        if (errors == errs_before) begin
            $display("%s: pass", name);
        end else begin
            tests_failed++;
            $display("%s: %0d errors", name, errors - errs_before);
        end
    endtask

    function automatic logic [31:0] mul_mod_q(input logic [23:0] a, input logic [22:0] b);
        longint prod;
        prod = longint'(a) * longint'(b);
        return 32'(prod % Q);
    endfunction

    // ========================================================================
    // AXI4-Lite master
    // ========================================================================
    task automatic next_cycle();
        @(posedge clk);
        #DRIVE_DLY;
    endtask

    // Keeps bready or rready low for a random stretch
    task automatic hold_ready_low(input logic stall);
        int n;
        n = stall ? int'($unsigned($random(seed)) % 8) : 0;
        repeat (n) next_cycle();
    endtask

    task automatic axi_write(input logic [11:0] addr, input logic [31:0] data,
                             input logic stall, output logic [1:0] resp);
        awaddr  = addr;
        wdata   = data;
        wstrb   = 4'hf;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        do begin
            next_cycle();
        end while (!(awready && wready));
        // Both channels transfer on this edge
        next_cycle();
        awvalid = 1'b0;
        wvalid  = 1'b0;
        hold_ready_low(stall);
        bready = 1'b1;
        while (!bvalid) next_cycle();
        resp = bresp;
        next_cycle();
        bready = 1'b0;
        if (bvalid)
            report_problem("write response was presented a second time");
    endtask

    task automatic axi_read(input logic [11:0] addr, input logic stall,
                            output logic [31:0] data, output logic [1:0] resp);
        araddr  = addr;
        arvalid = 1'b1;
        do begin
            next_cycle();
        end while (!arready);
        next_cycle();
        arvalid = 1'b0;
        hold_ready_low(stall);
        rready = 1'b1;
        while (!rvalid) next_cycle();
        data = rdata;
        resp = rresp;
        next_cycle();
        rready = 1'b0;
        if (rvalid)
            report_problem("read data was presented a second time");
    endtask

    task automatic write_expect(input logic [11:0] addr, input logic [31:0] data,
                                input logic stall, input logic [1:0] exp_resp);
        logic [1:0] resp;
        axi_write(addr, data, stall, resp);
        if (resp !== exp_resp)
            report_mismatch($sformatf("bresp at %h", addr), 32'(resp), 32'(exp_resp));
    endtask

    task automatic read_expect(input logic [11:0] addr, input logic stall,
                               input logic [31:0] exp_data, input logic [1:0] exp_resp,
                               input string name);
        logic [31:0] data;
        logic [1:0]  resp;
        axi_read(addr, stall, data, resp);
        if (resp !== exp_resp)
            report_mismatch($sformatf("rresp at %h", addr), 32'(resp), 32'(exp_resp));
        if (data !== exp_data)
            report_mismatch(name, data, exp_data);
    endtask

    // Polls status until done shows with busy clear
    task automatic wait_done(input logic stall);
        logic [31:0] data;
        logic [1:0]  resp;
        int          polls;
        polls = 0;
        do begin
            axi_read(STATUS_ADDR, stall, data, resp);
            polls++;
        end while ((data[1:0] !== 2'b01) && (polls < POLL_LIMIT));
        if (data[1:0] !== 2'b01)
            report_problem("engine did not report done with busy clear");
    endtask

    // ========================================================================
    // Tests
    // ========================================================================
    task automatic run_pass(input int idx);
        test_row_t   t;
        int          errs_before;
        logic [23:0] coef [`NTT_SLOTS];
        t = tests[idx];
        errs_before = errors;
        // Upper byte of the write data must not reach the slot
        for (int i = 0; i < `NTT_SLOTS; i++) begin
            coef[i] = 24'($unsigned($random(seed)) % Q);
            write_expect(12'(i * 4), {8'h5a, coef[i]}, t.stall, `NTT_RESP_OKAY);
        end
        read_expect(12'h000, t.stall, 32'(coef[0]), `NTT_RESP_OKAY, "rdata slot 0");
        read_expect(12'h3fc, t.stall, 32'(coef[255]), `NTT_RESP_OKAY, "rdata slot 255");
        write_expect(SCALAR_ADDR, 32'(t.scalar), t.stall, `NTT_RESP_OKAY);
        read_expect(SCALAR_ADDR, t.stall, 32'(t.scalar), `NTT_RESP_OKAY, "scalar");
        write_expect(CTRL_ADDR, 32'h1, t.stall, `NTT_RESP_OKAY);
        // The rejected write must leave the original coefficient in place
        if (t.busy_poke)
            write_expect(12'(POKE_SLOT * 4), 32'h00abcdef, t.stall, t.poke_resp);
        wait_done(t.stall);
        for (int i = 0; i < `NTT_SLOTS; i++) begin
            read_expect(12'(i * 4), t.stall, mul_mod_q(coef[i], t.scalar), `NTT_RESP_OKAY,
                        $sformatf("rdata slot %0d", i));
        end
        finish_test($sformatf("Test %0d scalar %0d", idx, t.scalar), errs_before);
    endtask

    task automatic check_out_of_range();
        int errs_before;
        errs_before = errors;
        // First hole above status, then the top of the byte space
        write_expect(12'h40c, 32'h1234, 1'b0, `NTT_RESP_SLVERR);
        read_expect(12'h40c, 1'b0, 32'h0, `NTT_RESP_SLVERR, "rdata at 40c");
        write_expect(12'hffc, 32'h5678, 1'b1, `NTT_RESP_SLVERR);
        read_expect(12'hffc, 1'b1, 32'h0, `NTT_RESP_SLVERR, "rdata at ffc");
        finish_test("Out of range access", errs_before);
    endtask

    task automatic check_zeroize();
        int errs_before;
        errs_before = errors;
        write_expect(CTRL_ADDR, 32'h2, 1'b0, `NTT_RESP_OKAY);
        for (int i = 0; i < `NTT_SLOTS; i++) begin
            read_expect(12'(i * 4), 1'b0, 32'h0, `NTT_RESP_OKAY,
                        $sformatf("rdata slot %0d", i));
        end
        read_expect(STATUS_ADDR, 1'b0, 32'h0, `NTT_RESP_OKAY, "status");
        finish_test("Zeroize", errs_before);
    endtask

    initial begin
        seed    = 32'ha13ede56;
        reset_n = 1'b0;
        awaddr  = '0;
        awvalid = 1'b0;
        wdata   = '0;
        wstrb   = '0;
        wvalid  = 1'b0;
        bready  = 1'b0;
        araddr  = '0;
        arvalid = 1'b0;
        rready  = 1'b0;
        // Scalar, stall, write while busy, response to that write
        tests[0] = '{23'd0,       1'b0, 1'b0, `NTT_RESP_OKAY};
        tests[1] = '{23'd1,       1'b0, 1'b1, `NTT_RESP_SLVERR};
        tests[2] = '{23'd8380416, 1'b1, 1'b0, `NTT_RESP_OKAY};
        tests[3] = '{23'd2718281, 1'b1, 1'b1, `NTT_RESP_SLVERR};
        tests[4] = '{23'd4190208, 1'b0, 1'b0, `NTT_RESP_OKAY};
        repeat (3) @(posedge clk);
        #DRIVE_DLY;
        reset_n = 1'b1;
        if (awready || wready || arready || bvalid || rvalid)
            report_problem("bus handshake outputs not idle after reset");
        for (int i = 0; i < NUM_TESTS; i++) begin
            run_pass(i);
        end
        check_out_of_range();
        check_zeroize();
        errors += uut.u_decode.u_axi_chk.fail_count + uut.u_result.u_eng_chk.fail_count;
        $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

//--- src.f
+incdir+hdl
hdl/ntt_pkg.sv
hdl/ntt_axil_decode.sv
hdl/ntt_special_mem.sv
hdl/ntt_pwm_execute.sv
hdl/ntt_pwm_result.sv
hdl/ntt_pwm_top.sv
bench/ntt_pwm_chk.sv
bench/ntt_pwm_tb.sv
